//--- cpu.f
source/cpu_pkg.sv
source/instr_memory.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/data_memory.sv
source/cpu.sv
sim/cpu_tb.sv

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
	import cpu_pkg::*;
();

	logic               clk;
	logic               rst;
	logic               prog_we;
	logic [imem_aw-1:0] prog_addr;
	logic [31:0]        prog_data;
	logic [31:0]        pc;
	wb_t                retire;
	logic               illegal;

	logic [31:0] prog [2][16];  // two load images, 16 reset cycles each
	int          plen [2];
	int          halt_w [2];     // word index of each self jump
	int          sec_first [6];
	int          sec_end [6];
	string       names [6] = '{"imm_arith", "r_alu", "memory", "branches", "jumps",
		"illegal_reset"};
	int          errs [7];       // slot 6 is the halt loop
	int          phase, cyc, last_sec, cur_sec, n_reported, n_passed;

	// reference model
	logic [31:0] mpc, mw, ma, mb, msx, mpc4, maddr, next_mpc;
	logic [31:0] mregs [32];
	logic [31:0] mmem [dmem_words];
	wb_t         exp_wb;
	logic        exp_ill, st_en;

	cpu cpu_i (
		.clk(clk),
		.rst(rst),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc(pc),
		.retire(retire),
		.illegal(illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_word(input logic [5:0] op, input int target);
		return {op, target[25:0]};  // target is a word index
	endfunction

	function automatic string test_name(input int s);
		return (s < 0) ? "halt" : names[s];
	endfunction

	// which test owns this address in the current image
	function automatic int section_of(input int ph, input logic [31:0] a);
		for (int s = ph * 3; s < ph * 3 + 3; s++) begin
			if (a[31:2] >= sec_first[s] && a[31:2] < sec_end[s]) begin
				return s;
			end
		end
		return -1;
	endfunction

	task automatic emit(input int ph, input logic [31:0] w);
		prog[ph][plen[ph]] = w;
		plen[ph]++;
	endtask

	task automatic build_programs();
		logic [15:0] im1, im2, im3, im4;
		im1 = 16'($urandom) | 16'h8000;  // negative, sign extension shows
		im2 = 16'($urandom) | 16'h8000;  // ori keeps upper half clear
		im3 = 16'($urandom);
		im4 = 16'($urandom) & 16'hfffc;  // word aligned data offset
		sec_first[0] = 0;
		emit(0, i_word(op_addi, 0, 1, im1));
		emit(0, i_word(op_ori, 0, 2, im2));
		emit(0, i_word(op_addi, 0, 0, im3));  // r0 write, must not stick
		emit(0, i_word(op_ori, 1, 3, im3));
		sec_end[0] = plen[0];
		sec_first[1] = plen[0];
		emit(0, r_word(1, 2, 4, fn_add));
		emit(0, r_word(0, 1, 5, fn_sub));  // 0 - r1, only if r0 still reads zero
		emit(0, r_word(1, 2, 6, fn_and));
		emit(0, r_word(2, 3, 7, fn_or));
		emit(0, r_word(1, 2, 8, fn_slt));  // negative < positive
		emit(0, r_word(2, 1, 9, fn_slt));
		sec_end[1] = plen[0];
		sec_first[2] = plen[0];
		emit(0, i_word(op_sw, 0, 4, im4));
		emit(0, i_word(op_lw, 0, 10, im4));
		emit(0, i_word(op_addi, 0, 11, im4));  // same address via a base reg
		emit(0, i_word(op_lw, 11, 12, 16'd0));
		emit(0, i_word(op_lw, 11, 13, 16'd4));  // neighbour, never stored
		sec_end[2] = plen[0];
		halt_w[0] = plen[0];
		emit(0, j_word(op_j, plen[0]));
		// second image runs on the registers left by the first
		sec_first[3] = 0;
		emit(1, i_word(op_beq, 10, 4, 16'd1));  // taken, r10 loaded back r4
		emit(1, i_word(op_addi, 0, 20, 16'd1));  // skipped
		emit(1, i_word(op_beq, 1, 2, 16'd1));  // falls through
		emit(1, i_word(op_bne, 1, 2, 16'd1));  // taken
		emit(1, i_word(op_addi, 0, 21, 16'd2));  // skipped
		emit(1, i_word(op_bne, 12, 4, 16'd1));  // falls through
		sec_end[3] = plen[1];
		sec_first[4] = plen[1];
		emit(1, j_word(op_jal, plen[1] + 2));
		emit(1, j_word(op_j, plen[1] + 3));  // jr lands here
		emit(1, r_word(31, 0, 0, fn_jr));
		emit(1, i_word(op_addi, 0, 22, 16'd3));  // skipped
		sec_end[4] = plen[1];
		sec_first[5] = plen[1];
		emit(1, {6'h3f, 26'($urandom)});  // unused opcode
		emit(1, r_word(1, 2, 23, 6'h00));  // funct 0, not supported
		sec_end[5] = plen[1];
		halt_w[1] = plen[1];
		emit(1, j_word(op_j, plen[1]));
	endtask

	// 16 reset cycles, one program word per cycle
	task automatic load_program(input int ph);
		for (int k = 0; k < 16; k++) begin
			@(posedge clk);
			rst <= 1'b1;
			phase <= ph;
			prog_we <= (k < plen[ph]);
			prog_addr <= imem_aw'(k);
			prog_data <= (k < plen[ph]) ? prog[ph][k] : '0;
		end
		@(posedge clk);
		rst <= 1'b0;
		prog_we <= 1'b0;
	endtask

	task automatic run_to_halt(input int ph, output bit ok);
		int n;
		n = 0;
		while (!(pc == 32'(halt_w[ph] * 4) && n_reported == 3 * (ph + 1)) && n < 2000) begin
			@(negedge clk);
			n++;
		end
		ok = (pc == 32'(halt_w[ph] * 4) && n_reported == 3 * (ph + 1));
	endtask

	task automatic value_error(input int s, input string what, input logic [31:0] exp, act);
		errs[s < 0 ? 6 : s]++;
		$display("Error %s %s: expected %h actual %h", test_name(s), what, exp, act);
	endtask

	task automatic wb_error(input int s, input wb_t exp, input wb_t act);
		errs[s < 0 ? 6 : s]++;
		$display("Error %s retire: expected we=%b r%0d=%h actual we=%b r%0d=%h",
			test_name(s), exp.we, exp.addr, exp.data, act.we, act.addr, act.data);
	endtask

	task automatic close_test(input int s);
		n_reported++;
		if (errs[s] == 0) begin
			n_passed++;
			$display("test %s: pass", names[s]);
		end else begin
			$display("test %s: fail, %0d errors", names[s], errs[s]);
		end
	endtask

	// expected effect of the word at mpc
	always_comb begin
		mw = prog[phase][mpc[5:2]];
		ma = mregs[mw[25:21]];
		mb = mregs[mw[20:16]];
		msx = {{16{mw[15]}}, mw[15:0]};
		mpc4 = mpc + 32'd4;
		maddr = ma + msx;
		next_mpc = mpc4;
		exp_wb = '0;
		exp_ill = 1'b0;
		st_en = 1'b0;
		case (mw[31:26])
			op_rtype: begin
				exp_wb = '{we: 1'b1, addr: mw[15:11], data: 32'd0};
				case (mw[5:0])
					fn_add: exp_wb.data = ma + mb;
					fn_sub: exp_wb.data = ma - mb;
					fn_and: exp_wb.data = ma & mb;
					fn_or:  exp_wb.data = ma | mb;
					fn_slt: exp_wb.data = ($signed(ma) < $signed(mb)) ? 32'd1 : 32'd0;
					fn_jr: begin
						exp_wb.we = 1'b0;
						next_mpc = ma;
					end
					default: begin
						exp_wb.we = 1'b0;
						exp_ill = 1'b1;
					end
				endcase
			end
			op_addi: exp_wb = '{we: 1'b1, addr: mw[20:16], data: ma + msx};
			op_ori:  exp_wb = '{we: 1'b1, addr: mw[20:16], data: ma | {16'b0, mw[15:0]}};
			op_lw:   exp_wb = '{we: 1'b1, addr: mw[20:16], data: mmem[maddr[dmem_aw+1:2]]};
			op_sw:   st_en = 1'b1;
			op_beq:  next_mpc = (ma == mb) ? mpc4 + {msx[29:0], 2'b00} : mpc4;
			op_bne:  next_mpc = (ma != mb) ? mpc4 + {msx[29:0], 2'b00} : mpc4;
			op_j:    next_mpc = {mpc4[31:28], mw[25:0], 2'b00};
			op_jal: begin
				exp_wb = '{we: 1'b1, addr: 5'd31, data: mpc4};  // link
				next_mpc = {mpc4[31:28], mw[25:0], 2'b00};
			end
			default: exp_ill = 1'b1;
		endcase
	end

	always @(posedge clk) begin
		if (rst) begin
			mpc <= '0;
		end else begin
			if (exp_wb.we && exp_wb.addr != 5'd0) begin
				mregs[exp_wb.addr] <= exp_wb.data;
			end
			if (st_en) begin
				mmem[maddr[dmem_aw+1:2]] <= mb;
			end
			mpc <= next_mpc;
		end
	end

	always_comb cur_sec = section_of(phase, mpc);

	// pass/fail line once the model pc leaves a test
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (!rst && cur_sec != last_sec) begin
			if (last_sec >= 0) begin
				close_test(last_sec);
			end
			last_sec <= cur_sec;
		end
	end

	a_retire: assert property (@(posedge clk) disable iff (rst)
		retire.we == exp_wb.we && (!exp_wb.we || retire == exp_wb))
		else wb_error($sampled(cur_sec), $sampled(exp_wb), $sampled(retire));
	a_pc: assert property (@(posedge clk) disable iff (rst) pc == mpc)
		else value_error($sampled(cur_sec), "pc", $sampled(mpc), $sampled(pc));
	a_illegal: assert property (@(posedge clk) disable iff (rst) illegal == exp_ill)
		else value_error($sampled(cur_sec), "illegal", 32'($sampled(exp_ill)),
			32'($sampled(illegal)));
	// pc settles one edge after rst rises
	a_reset_pc: assert property (@(posedge clk) (cyc > 0 && rst && $past(rst)) |-> pc == 32'd0)
		else value_error(5, "reset pc", 32'd0, $sampled(pc));
	a_reset_we: assert property (@(posedge clk) rst |-> !retire.we)
		else value_error(5, "reset retire.we", 32'd0, 32'($sampled(retire.we)));

	initial begin
		bit ok;
		int total;
		void'($urandom(72333));
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		phase = 0;
		cyc = 0;
		last_sec = -1;
		n_reported = 0;
		n_passed = 0;
		total = 0;
		foreach (errs[i]) errs[i] = 0;
		foreach (mregs[i]) mregs[i] = '0;
		foreach (mmem[i]) mmem[i] = '0;  // dmem powers up cleared too
		build_programs();
		load_program(0);
		run_to_halt(0, ok);
		if (ok) begin
			load_program(1);  // second reset mid run
			run_to_halt(1, ok);
		end
		if (!ok) begin
			$display("timeout: the program never reached its final self-jump");
		end
		foreach (errs[i]) total += errs[i];
		$display("tests: %0d passed, %0d failed, %0d errors", n_passed, 6 - n_passed, total);
		if (ok && total == 0 && n_passed == 6) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- source/cpu.sv
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               prog_we,
	input  logic [imem_aw-1:0] prog_addr,  // word address
	input  logic [31:0]        prog_data,
	output logic [31:0]        pc,
	output wb_t                retire,
	output logic               illegal
);

	logic [31:0] instr_word;
	instr_u      instr;
	ctrl_t       ctrl;
	logic [31:0] rs_data, rt_data;
	logic [31:0] imm_ext;
	logic [31:0] alu_b, alu_result;
	logic        alu_zero;
	logic [31:0] dm_rdata;
	logic [31:0] pc_plus4, branch_target, jump_target, next_pc;
	logic        taken;

	instr_memory imem_i (
		.clk(clk),
		.we(prog_we),
		.waddr(prog_addr),
		.wdata(prog_data),
		.raddr(pc[imem_aw+1:2]),  // drop byte offset
		.rdata(instr_word)
	);

	assign instr = instr_word;

	instr_decoder dec_i (.instr(instr), .ctrl(ctrl));

	reg_file rf_i (
		.clk(clk),
		.raddr_a(instr.r.rs),
		.raddr_b(instr.r.rt),
		.rdata_a(rs_data),
		.rdata_b(rt_data),
		.wb(retire)  // same record as seen outside
	);

	// ori zero extends, everything else sign extends
	assign imm_ext = ctrl.zero_ext ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
	assign alu_b = ctrl.use_imm ? imm_ext : rt_data;

	alu alu_i (.a(rs_data), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .zero(alu_zero));

	data_memory dmem_i (
		.clk(clk),
		.we(ctrl.dm_we && !rst),  // no stores while loading
		.addr(alu_result[dmem_aw+1:2]),
		.wdata(rt_data),
		.rdata(dm_rdata)
	);

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
	assign jump_target = {pc_plus4[31:28], instr.j.target, 2'b00};
	assign taken = ctrl.branch && (alu_zero != ctrl.branch_ne);  // beq on zero, bne on nonzero

	always_comb begin
		case (ctrl.pc_sel)
			pc_seq:    next_pc = pc_plus4;
			pc_branch: next_pc = taken ? branch_target : pc_plus4;
			pc_jump:   next_pc = jump_target;
			pc_reg:    next_pc = rs_data;  // jr
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;  // held at 0 during program load
		end else begin
			pc <= next_pc;
		end
	end

	// write back for the instruction at pc
	always_comb begin
		retire.we = ctrl.rf_we && !rst;
		case (ctrl.wdst)
			wd_rd:   retire.addr = instr.r.rd;
			wd_ra:   retire.addr = 5'd31;
			default: retire.addr = instr.r.rt;
		endcase
		case (ctrl.wb_src)
			wb_mem:  retire.data = dm_rdata;
			wb_link: retire.data = pc_plus4;  // jal return address
			default: retire.data = alu_result;
		endcase
	end

	assign illegal = ctrl.illegal;

	// jr to an odd address would break fetch
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);
	// skipped illegal word just steps over
	a_illegal_steps: assert property (
		@(posedge clk) disable iff (rst) illegal |=> pc == $past(pc) + 32'd4
	);

endmodule

//--- source/data_memory.sv
`timescale 1ns/1ps

module data_memory
	import cpu_pkg::*;
(
	input  logic               clk,
	input  logic               we,
	input  logic [dmem_aw-1:0] addr,  // word address
	input  logic [31:0]        wdata,
	output logic [31:0]        rdata
);

	logic [31:0] mem [dmem_words];

	// power up as zero, unwritten words read back 0
	initial begin
		for (int i = 0; i < dmem_words; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;  // sw commits at end of its cycle
		end
	end

	assign rdata = mem[addr];  // lw sees it same cycle

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu
	import cpu_pkg::*;
(
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  alu_op_e     op,
	output logic [31:0] result,
	output logic        zero
);

	logic lt;  // signed a < b

	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: result = a + b;  // no overflow trap
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'b0, lt};
			default: result = '0;
		endcase
	end

	// beq/bne look at this with alu_sub
	assign zero = (result == 32'd0);

	// decoder only emits the five defined codes
	a_op_legal: assert final (
		$isunknown(op) || op inside {alu_add, alu_sub, alu_and, alu_or, alu_slt}
	);

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic [4:0]  raddr_a,  // rs
	input  logic [4:0]  raddr_b,  // rt
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b,
	input  wb_t         wb
);

	logic [31:0] regs [1:31];  // r0 has no storage

	always_ff @(posedge clk) begin
		if (wb.we && wb.addr != 5'd0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// plain reads, the write lands at the clock edge
	always_comb begin
		rdata_a = '0;
		rdata_b = '0;
		if (raddr_a != 5'd0) begin
			rdata_a = regs[raddr_a];
		end
		if (raddr_b != 5'd0) begin
			rdata_b = regs[raddr_b];
		end
	end

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import cpu_pkg::*;
(
	input  instr_u instr,
	output ctrl_t  ctrl
);

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;  // address calc and addi
		ctrl.pc_sel = pc_seq;
		ctrl.wb_src = wb_alu;
		ctrl.wdst = wd_rt;

		case (instr.r.opcode)
			op_rtype: begin
				ctrl.wdst = wd_rd;
				ctrl.rf_we = 1'b1;
				case (instr.r.funct)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or: ctrl.alu_op = alu_or;
					fn_slt: ctrl.alu_op = alu_slt;
					fn_jr: begin
						ctrl.pc_sel = pc_reg;  // target is rs
						ctrl.rf_we = 1'b0;
					end
					default: begin
						ctrl.rf_we = 1'b0;
						ctrl.illegal = 1'b1;
					end
				endcase
			end
			op_addi: begin
				ctrl.use_imm = 1'b1;  // sign extended
				ctrl.rf_we = 1'b1;
			end
			op_ori: begin
				ctrl.alu_op = alu_or;
				ctrl.use_imm = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.rf_we = 1'b1;
			end
			op_lw: begin
				ctrl.use_imm = 1'b1;
				ctrl.wb_src = wb_mem;
				ctrl.rf_we = 1'b1;
			end
			op_sw: begin
				ctrl.use_imm = 1'b1;
				ctrl.dm_we = 1'b1;
			end
			op_beq, op_bne: begin
				ctrl.alu_op = alu_sub;  // rs - rt, zero means equal
				ctrl.branch = 1'b1;
				ctrl.branch_ne = (instr.r.opcode == op_bne);
				ctrl.pc_sel = pc_branch;
			end
			op_j: ctrl.pc_sel = pc_jump;
			op_jal: begin
				ctrl.pc_sel = pc_jump;
				ctrl.rf_we = 1'b1;
				ctrl.wb_src = wb_link;  // pc + 4
				ctrl.wdst = wd_ra;      // r31
			end
			default: ctrl.illegal = 1'b1;  // unknown opcode, no writes
		endcase
	end

	// an illegal word must never reach either write port
	a_illegal_no_write: assert final (
		$isunknown(instr) || !(ctrl.illegal && (ctrl.rf_we || ctrl.dm_we))
	);

endmodule

//--- source/instr_memory.sv
`timescale 1ns/1ps

module instr_memory
	import cpu_pkg::*;
(
	input  logic               clk,
	input  logic               we,
	input  logic [imem_aw-1:0] waddr,
	input  logic [31:0]        wdata,
	input  logic [imem_aw-1:0] raddr,
	output logic [31:0]        rdata
);

	logic [31:0] mem [imem_words];  // program store, no reset

	// load port, only used while the core is held in reset
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// fetch is async so the whole instruction fits in one cycle
	assign rdata = mem[raddr];

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

	// memory sizes, both word addressed
	localparam int imem_words = 256;
	localparam int imem_aw    = 8;  // log2(imem_words)
	localparam int dmem_words = 256;
	localparam int dmem_aw    = 8;  // log2(dmem_words)

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_ori   = 6'h0d,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// function codes for op_rtype, instr[5:0]
	typedef enum logic [5:0] {
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4  // signed compare
	} alu_op_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;  // unused, no shifts
		funct_e     funct;
	} r_fields_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target;  // word index in the current 256MB region
	} j_fields_t;

	// one instruction word, three views
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_u;

	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_sel_e;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_src_e;
	typedef enum logic [1:0] {wd_rt, wd_rd, wd_ra} wdst_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;    // operand b from immediate
		logic    zero_ext;   // ori style extension
		logic    branch;
		logic    branch_ne;  // take branch on nonzero
		pc_sel_e pc_sel;
		logic    rf_we;
		wb_src_e wb_src;
		wdst_e   wdst;
		logic    dm_we;
		logic    illegal;
	} ctrl_t;

	// register write, also the retire record
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_t;

endpackage
